// ==== Makefile ====
# Verilator build and run of the branch predictor testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module branchPredictorTb \
		-f branchPredictor.f -o simBranchPredictor

run: compile
	./obj_dir/simBranchPredictor > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@if ! grep -q "Test passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== branchPredictor.f ====
design/predictorPkg.sv
design/lookupRam.sv
design/branchTargetTable.sv
design/historyTrainer.sv
design/historyTable.sv
design/branchPredictor.sv
test/branchPredictor_assertions.sv
test/branchPredictorTb.sv

// ==== design/branchPredictor.sv ====
/*
 * Branch predictor top level. Target table plus history table, with
 * independent build, train and predict ports.
 */
`timescale 1ns/100ps
`default_nettype none

module branchPredictor (
    input  wire                        clk,
    input  wire                        rstn,

    // build port
    input  wire                        buildEn,
    input  wire  predictorPkg::addrT   buildPc,
    input  wire  predictorPkg::addrT   buildTarget,
    input  wire  predictorPkg::brTypeT buildType,

    // train port
    input  wire                        trainEn,
    input  wire  predictorPkg::addrT   trainPc,
    input  wire                        trainTaken,
    input  wire                        trainBack,
    input  wire  predictorPkg::brTypeT trainType,

    // predict port
    input  wire  predictorPkg::addrT   predPc,
    output wire                        predHit,
    output wire  predictorPkg::addrT   predTarget,
    output wire  predictorPkg::brTypeT predType,
    output wire                        predHistVld,
    output wire                        predTaken
);

    branchTargetTable u_branchTargetTable (
        .clk         (clk),
        .rstn        (rstn),
        .buildEn     (buildEn),
        .buildPc     (buildPc),
        .buildTarget (buildTarget),
        .buildType   (buildType),
        .predPc      (predPc),
        .predHit     (predHit),
        .predTarget  (predTarget),
        .predType    (predType)
    );

    // any build restarts the slot's history
    historyTable u_historyTable (
        .clk         (clk),
        .rstn        (rstn),
        .eraseEn     (buildEn),
        .erasePc     (buildPc),
        .trainEn     (trainEn),
        .trainPc     (trainPc),
        .trainTaken  (trainTaken),
        .trainBack   (trainBack),
        .trainType   (trainType),
        .predPc      (predPc),
        .predHistVld (predHistVld),
        .predTaken   (predTaken)
    );

endmodule

`default_nettype wire

// ==== design/branchTargetTable.sv ====
/*
 * Branch target table. Records tag, target and type per slot on build,
 * and returns hit, target and type for the predict PC.
 */
`timescale 1ns/100ps
`default_nettype none

module branchTargetTable (
    input  wire                        clk,
    input  wire                        rstn,

    input  wire                        buildEn,
    input  wire  predictorPkg::addrT   buildPc,
    input  wire  predictorPkg::addrT   buildTarget,
    input  wire  predictorPkg::brTypeT buildType,

    input  wire  predictorPkg::addrT   predPc,
    output logic                       predHit,
    output predictorPkg::addrT         predTarget,
    output predictorPkg::brTypeT       predType
);

    localparam int IDX_LO = 2;
    localparam int TAG_LO = predictorPkg::INDEX_WIDTH + 2;

    predictorPkg::indexT buildIdx;
    predictorPkg::indexT predIdx;
    predictorPkg::tagT   buildTag;
    predictorPkg::tagT   predTag;
    predictorPkg::tagT   storedTag;
    predictorPkg::entryT buildEntry;
    predictorPkg::entryT storedEntry;
    logic                buildUseful;
    logic [predictorPkg::SLOTS - 1:0] targetVld;

    assign buildIdx = buildPc[TAG_LO - 1:IDX_LO];
    assign predIdx  = predPc[TAG_LO - 1:IDX_LO];
    assign buildTag = buildPc[predictorPkg::ADDR_WIDTH - 1:TAG_LO];
    assign predTag  = predPc[predictorPkg::ADDR_WIDTH - 1:TAG_LO];

    // only real branches occupy a slot
    assign buildUseful = (buildType == predictorPkg::COND) ||
                         (buildType == predictorPkg::JUMP);
    assign buildEntry  = {buildTarget[predictorPkg::ADDR_WIDTH - 1:2], buildType};

    //////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            targetVld <= '0;
        end else if (buildEn) begin
            targetVld[buildIdx] <= buildUseful;         // non-branch build clears
        end
    end

    lookupRam #(.payloadT(predictorPkg::tagT)) u_tagRam (
        .clk    (clk),
        .we     (buildEn & buildUseful),
        .waddr  (buildIdx),
        .wdata  (buildTag),
        .raddrA (predIdx),
        .rdataA (storedTag),
        .raddrB (buildIdx),
        .rdataB ()                                      // spare port
    );

    lookupRam #(.payloadT(predictorPkg::entryT)) u_entryRam (
        .clk    (clk),
        .we     (buildEn & buildUseful),
        .waddr  (buildIdx),
        .wdata  (buildEntry),
        .raddrA (predIdx),
        .rdataA (storedEntry),
        .raddrB (buildIdx),
        .rdataB ()                                      // spare port
    );

    //////////////////////////////////////////////////
    // predict lookup
    //////////////////////////////////////////////////
    assign predHit    = targetVld[predIdx] && (storedTag == predTag);
    assign predTarget = {storedEntry[predictorPkg::ADDR_WIDTH - 1:2], 2'b00};
    assign predType   = predictorPkg::brTypeT'(storedEntry[1:0]);

endmodule

`default_nettype wire

// ==== design/historyTable.sv ====
/*
 * Pattern history table. Trains a local history word per slot, erases
 * slots that get rebuilt, and gives the taken guess for the predict PC.
 */
`timescale 1ns/100ps
`default_nettype none

module historyTable (
    input  wire                        clk,
    input  wire                        rstn,

    input  wire                        eraseEn,
    input  wire  predictorPkg::addrT   erasePc,

    input  wire                        trainEn,
    input  wire  predictorPkg::addrT   trainPc,
    input  wire                        trainTaken,
    input  wire                        trainBack,
    input  wire  predictorPkg::brTypeT trainType,

    input  wire  predictorPkg::addrT   predPc,
    output logic                       predHistVld,
    output logic                       predTaken
);

    localparam int IDX_HI = predictorPkg::INDEX_WIDTH + 1;
    localparam int HI     = predictorPkg::HIST_WIDTH - 1;

    predictorPkg::indexT   eraseIdx;
    predictorPkg::indexT   trainIdx;
    predictorPkg::indexT   predIdx;
    predictorPkg::historyT oldWord;
    predictorPkg::historyT initWord;
    predictorPkg::historyT nextWord;
    predictorPkg::historyT writeWord;
    predictorPkg::historyT predWord;
    logic [1:0]            predHist;
    logic [1:0]            predCtr;
    logic [predictorPkg::SLOTS - 1:0] histVld;

    assign eraseIdx = erasePc[IDX_HI:2];
    assign trainIdx = trainPc[IDX_HI:2];
    assign predIdx  = predPc[IDX_HI:2];

    //////////////////////////////////////////////////
    // valid bits, erase has the last word
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            histVld <= '0;
        end else begin
            if (trainEn) begin
                histVld[trainIdx] <= 1'b1;
            end
            if (eraseEn) begin
                histVld[eraseIdx] <= 1'b0;              // wins on same index
            end
        end
    end

    historyTrainer u_historyTrainer (
        .taken  (trainTaken),
        .back   (trainBack),
        .brType (trainType),
        .old    (oldWord),
        .init   (initWord),
        .next   (nextWord)
    );

    // stale contents of an invalid slot are never trained on
    assign writeWord = histVld[trainIdx] ? nextWord : initWord;

    lookupRam #(.payloadT(predictorPkg::historyT)) u_historyRam (
        .clk    (clk),
        .we     (trainEn),
        .waddr  (trainIdx),
        .wdata  (writeWord),
        .raddrA (trainIdx),
        .rdataA (oldWord),
        .raddrB (predIdx),
        .rdataB (predWord)
    );

    //////////////////////////////////////////////////
    // taken guess
    //////////////////////////////////////////////////
    assign predHistVld = histVld[predIdx];
    assign predHist    = predWord[HI -: 2];
    assign predCtr     = predWord[{predHist, 1'b0} +: 2];
    assign predTaken   = predCtr[1];                    // counter msb

endmodule

`default_nettype wire

// ==== design/historyTrainer.sv ====
/*
 * History trainer. Builds the first history word of a slot and the
 * trained word: shifted local history plus one saturating counter step.
 */
`timescale 1ns/100ps
`default_nettype none

module historyTrainer (
    input  wire                        taken,
    input  wire                        back,
    input  wire  predictorPkg::brTypeT brType,
    input  wire  predictorPkg::historyT old,
    output predictorPkg::historyT      init,
    output predictorPkg::historyT      next
);

    localparam int HI = predictorPkg::HIST_WIDTH - 1;

    logic [1:0] oldHist;
    logic [1:0] oldCtr;
    logic [1:0] newCtr;

    //////////////////////////////////////////////////
    // first word of a fresh slot
    //////////////////////////////////////////////////
    always_comb begin
        case (brType)
            predictorPkg::JUMP: init = '1;              // always taken
            predictorPkg::COND: begin
                // backward branches start biased towards taken
                init = {back, taken, back ? 8'b10_10_10_01 : 8'b10_01_01_01};
            end
            default:            init = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // trained word
    //////////////////////////////////////////////////
    assign oldHist = old[HI -: 2];
    assign oldCtr  = old[{oldHist, 1'b0} +: 2];         // counter picked by history

    always_comb begin
        if (taken) begin
            newCtr = (oldCtr == 2'b11) ? 2'b11 : oldCtr + 2'd1;     // saturate high
        end else begin
            newCtr = (oldCtr == 2'b00) ? 2'b00 : oldCtr - 2'd1;     // saturate low
        end
    end

    always_comb begin
        next = old;
        next[{oldHist, 1'b0} +: 2] = newCtr;
        next[HI -: 2] = {old[HI - 1], taken};           // newer moves to older
    end

endmodule

`default_nettype wire

// ==== design/lookupRam.sv ====
/*
 * Small lookup RAM for any payload type.
 * One synchronous write port, two combinational read ports, no reset.
 */
`timescale 1ns/100ps
`default_nettype none

module lookupRam #(
    parameter type payloadT   = logic [7:0],
    parameter int  DEPTH_BITS = predictorPkg::INDEX_WIDTH
) (
    input  wire                       clk,
    input  wire                       we,
    input  wire  predictorPkg::indexT waddr,
    input  wire  payloadT             wdata,
    input  wire  predictorPkg::indexT raddrA,
    output payloadT                   rdataA,
    input  wire  predictorPkg::indexT raddrB,
    output payloadT                   rdataB
);

    payloadT mem [0:(1 << DEPTH_BITS) - 1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;                        // visible to reads next cycle
        end
    end

    assign rdataA = mem[raddrA];
    assign rdataB = mem[raddrB];

endmodule

`default_nettype wire

// ==== design/predictorPkg.sv ====
/*
 * Branch predictor shared definitions: table geometry, PC field types,
 * branch type encoding, target entry and local history word.
 */
`default_nettype none

package predictorPkg;

    //////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////
    localparam int ADDR_WIDTH  = 32;                    // processor address width
    localparam int INDEX_WIDTH = 5;                     // 32 slots
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - 2;
    localparam int SLOTS       = 1 << INDEX_WIDTH;
    localparam int HIST_WIDTH  = 10;                    // 2 history bits + 4 counters

    //////////////////////////////////////////////////
    // PC fields
    //////////////////////////////////////////////////
    typedef logic [ADDR_WIDTH - 1:0]  addrT;
    typedef logic [INDEX_WIDTH - 1:0] indexT;           // pc[6:2]
    typedef logic [TAG_WIDTH - 1:0]   tagT;             // pc[31:7]

    // 2'b11 is not a branch either, handled like NONE
    typedef enum logic [1:0] {
        NONE = 2'b00,                                   // not a branch
        COND = 2'b01,                                   // conditional branch
        JUMP = 2'b10                                    // unconditional jump
    } brTypeT;

    /*
     * target entry layout, high to low
     *   target  30  target address bits 31:2
     *   type     2  brTypeT of the instruction
     */
    typedef logic [ADDR_WIDTH - 1:0] entryT;

    /*
     * history word layout, high to low
     *   hist     2  older outcome, newer outcome
     *   ctr     8  counters for history 11, 10, 01, 00
     */
    typedef logic [HIST_WIDTH - 1:0] historyT;

endpackage

`default_nettype wire

// ==== test/branchPredictorTb.sv ====
/*
 * Branch predictor testbench. Directed table plus LFSR rows, checked
 * against a reference model of target and history tables.
 */
`timescale 1ns/100ps
`default_nettype none

module branchPredictorTb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_ROWS  = 400;

    localparam logic [1:0] OP_BUILD = 2'd0;
    localparam logic [1:0] OP_TRAIN = 2'd1;
    localparam logic [1:0] OP_BOTH  = 2'd2;             // build at pc, train at pc2
    localparam logic [1:0] OP_PRED  = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] pc;
        logic [31:0] pc2;
        logic [31:0] target;
        logic [1:0]  brType;
        logic        taken;
        logic        back;
    } rowT;

    logic                 clk = 1'b0;
    logic                 rstn;
    logic                 buildEn;
    predictorPkg::addrT   buildPc;
    predictorPkg::addrT   buildTarget;
    predictorPkg::brTypeT buildType;
    logic                 trainEn;
    predictorPkg::addrT   trainPc;
    logic                 trainTaken;
    logic                 trainBack;
    predictorPkg::brTypeT trainType;
    predictorPkg::addrT   predPc;
    logic                 predHit;
    predictorPkg::addrT   predTarget;
    predictorPkg::brTypeT predType;
    logic                 predHistVld;
    logic                 predTaken;

    // reference model
    logic        mTgtVld  [32];
    logic [24:0] mTag     [32];
    logic [31:0] mTarget  [32];
    logic [1:0]  mType    [32];
    logic        mHistVld [32];
    logic [1:0]  mHist    [32];
    logic [1:0]  mCtr     [32][4];

    rowT         rows[$];
    logic [31:0] lfsrState;

    always #(CLK_PERIOD / 2) clk = ~clk;

    branchPredictor u_branchPredictor (.*);

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic int slotOf(input logic [31:0] pc);
        return int'(pc[6:2]);
    endfunction

    function automatic logic [31:0] pcOf(input logic [24:0] tag, input logic [4:0] idx);
        return {tag, idx, 2'b00};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] randPc();
        logic [31:0] t;
        logic [31:0] idx;
        logic [24:0] tag;
        t = randBits(2);
        idx = randBits(3);                              // 8 indices
        tag = (t == 1) ? 25'h155_5555 : (t == 2) ? 25'h0ab_cdef : 25'h000_00a5;
        return pcOf(tag, idx[4:0]);
    endfunction

    task automatic addRow(input logic [1:0] op, input logic [31:0] pc, input logic [31:0] pc2,
                          input logic [31:0] target, input logic [1:0] brType,
                          input logic taken, input logic back);
        rowT r;
        r = '{op, pc, pc2, target, brType, taken, back};
        rows.push_back(r);
    endtask

    task automatic stopRun();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic failValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        stopRun();
    endtask

    //////////////////////////////////////////////////
    // model updates
    //////////////////////////////////////////////////
    task automatic modelTrain(input logic [31:0] pc, input logic taken, input logic back,
                              input logic [1:0] brType);
        int s;
        int h;
        int c;
        s = slotOf(pc);
        if (mHistVld[s]) begin
            h = int'(mHist[s]);
            if (taken && mCtr[s][h] != 2'b11) begin
                mCtr[s][h] = mCtr[s][h] + 2'd1;
            end else if (!taken && mCtr[s][h] != 2'b00) begin
                mCtr[s][h] = mCtr[s][h] - 2'd1;
            end
            mHist[s] = {mHist[s][0], taken};            // newer becomes older
        end else if (brType == 2'b10) begin
            mHist[s] = 2'b11;
            for (c = 0; c < 4; c++) mCtr[s][c] = 2'b11;
        end else if (brType == 2'b01) begin
            mHist[s] = {back, taken};
            mCtr[s][3] = 2'b10;
            mCtr[s][2] = back ? 2'b10 : 2'b01;
            mCtr[s][1] = back ? 2'b10 : 2'b01;
            mCtr[s][0] = 2'b01;
        end else begin
            mHist[s] = 2'b00;
            for (c = 0; c < 4; c++) mCtr[s][c] = 2'b00;
        end
        mHistVld[s] = 1'b1;
    endtask

    task automatic modelBuild(input logic [31:0] pc, input logic [31:0] target,
                              input logic [1:0] brType);
        int s;
        s = slotOf(pc);
        mTgtVld[s] = (brType == 2'b01) || (brType == 2'b10);
        if (mTgtVld[s]) begin
            mTag[s] = pc[31:7];
            mTarget[s] = {target[31:2], 2'b00};
            mType[s] = brType;
        end
        mHistVld[s] = 1'b0;                             // every build erases
    endtask

    task automatic checkPredict(input logic [31:0] pc);
        int   s;
        logic expHit;
        logic expTaken;
        s = slotOf(pc);
        expHit = mTgtVld[s] && (mTag[s] == pc[31:7]);
        assert (predHit === expHit) else failValue("predHit", 32'(expHit), 32'(predHit));
        if (expHit) begin
            assert (predTarget === mTarget[s])
                else failValue("predTarget", mTarget[s], predTarget);
            assert (predType === mType[s])
                else failValue("predType", 32'(mType[s]), 32'(predType));
        end
        assert (predHistVld === mHistVld[s])
            else failValue("predHistVld", 32'(mHistVld[s]), 32'(predHistVld));
        if (mHistVld[s]) begin
            expTaken = mCtr[s][int'(mHist[s])][1];
            assert (predTaken === expTaken)
                else failValue("predTaken", 32'(expTaken), 32'(predTaken));
        end
    endtask

    // drive one row at edge + 1, check or commit at the next edge
    task automatic applyRow(input rowT r);
        buildEn     = (r.op == OP_BUILD) || (r.op == OP_BOTH);
        buildPc     = r.pc;
        buildTarget = r.target;
        buildType   = predictorPkg::brTypeT'(r.brType);
        trainEn     = (r.op == OP_TRAIN) || (r.op == OP_BOTH);
        trainPc     = (r.op == OP_BOTH) ? r.pc2 : r.pc;
        trainTaken  = r.taken;
        trainBack   = r.back;
        trainType   = predictorPkg::brTypeT'(r.brType);
        predPc      = r.pc;
        if (r.op == OP_PRED) begin
            #2;
            checkPredict(r.pc);
        end
        @(posedge clk);
        #1;
        if (trainEn) modelTrain(trainPc, r.taken, r.back, r.brType);
        if (buildEn) modelBuild(r.pc, r.target, r.brType);     // erase lands last
        buildEn = 1'b0;
        trainEn = 1'b0;
    endtask

    task automatic waitResetClear();
        int cycles;
        cycles = 0;
        #2;
        while (predHit !== 1'b0 || predHistVld !== 1'b0) begin
            if (cycles == 4) begin
                $display("predict outputs did not clear within 4 cycles of reset");
                stopRun();
            end
            @(posedge clk);
            #3;
            cycles++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic buildTable();
        int i;
        // after reset
        addRow(OP_PRED, pcOf(25'd0, 5'd0), 0, 0, 2'b00, 0, 0);
        addRow(OP_PRED, pcOf(25'd5, 5'd3), 0, 0, 2'b00, 0, 0);
        addRow(OP_PRED, pcOf(25'h1ff_ffff, 5'd31), 0, 0, 2'b00, 0, 0);
        // build, alias miss, jump, non-branch clear
        addRow(OP_BUILD, pcOf(25'd1, 5'd4), 0, 32'h0000_1230, 2'b01, 0, 0);
        addRow(OP_PRED, pcOf(25'd1, 5'd4), 0, 0, 2'b00, 0, 0);
        addRow(OP_PRED, pcOf(25'd2, 5'd4), 0, 0, 2'b00, 0, 0);
        addRow(OP_BUILD, pcOf(25'd3, 5'd9), 0, 32'hdead_beef, 2'b10, 0, 0);
        addRow(OP_PRED, pcOf(25'd3, 5'd9), 0, 0, 2'b00, 0, 0);
        addRow(OP_BUILD, pcOf(25'd3, 5'd9), 0, 32'h0, 2'b00, 0, 0);
        addRow(OP_PRED, pcOf(25'd3, 5'd9), 0, 0, 2'b00, 0, 0);
        addRow(OP_BUILD, pcOf(25'd1, 5'd4), 0, 32'h0, 2'b11, 0, 0);
        addRow(OP_PRED, pcOf(25'd1, 5'd4), 0, 0, 2'b00, 0, 0);
        // first COND train, every back and taken pair
        for (i = 0; i < 4; i++) begin
            addRow(OP_TRAIN, pcOf(25'd1, 5'(10 + i)), 0, 0, 2'b01, i[0], i[1]);
            addRow(OP_PRED, pcOf(25'd1, 5'(10 + i)), 0, 0, 2'b00, 0, 0);
        end
        // saturate up then down
        for (i = 0; i < 12; i++) begin
            addRow(OP_TRAIN, pcOf(25'd1, 5'd10), 0, 0, 2'b01, i < 6, 0);
            addRow(OP_PRED, pcOf(25'd1, 5'd10), 0, 0, 2'b00, 0, 0);
        end
        // rebuild, same-index collision, different indices
        addRow(OP_BUILD, pcOf(25'd1, 5'd10), 0, 32'h0000_4000, 2'b01, 0, 0);
        addRow(OP_PRED, pcOf(25'd1, 5'd10), 0, 0, 2'b00, 0, 0);
        addRow(OP_BOTH, pcOf(25'd1, 5'd11), pcOf(25'd1, 5'd11), 32'h80, 2'b01, 1, 0);
        addRow(OP_PRED, pcOf(25'd1, 5'd11), 0, 0, 2'b00, 0, 0);
        addRow(OP_BOTH, pcOf(25'd4, 5'd14), pcOf(25'd4, 5'd15), 32'h100, 2'b01, 1, 1);
        addRow(OP_PRED, pcOf(25'd4, 5'd14), 0, 0, 2'b00, 0, 0);
        addRow(OP_PRED, pcOf(25'd4, 5'd15), 0, 0, 2'b00, 0, 0);
        // jump from an invalid slot
        addRow(OP_TRAIN, pcOf(25'd6, 5'd20), 0, 0, 2'b10, 0, 0);
        addRow(OP_PRED, pcOf(25'd6, 5'd20), 0, 0, 2'b00, 0, 0);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        rowT r;
        int  i;
        lfsrState = 32'hc0b6;
        rstn = 1'b0;
        buildEn = 1'b0;
        buildPc = '0;
        buildTarget = '0;
        buildType = predictorPkg::NONE;
        trainEn = 1'b0;
        trainPc = '0;
        trainTaken = 1'b0;
        trainBack = 1'b0;
        trainType = predictorPkg::NONE;
        predPc = '0;
        for (i = 0; i < 32; i++) begin
            mTgtVld[i] = 1'b0;
            mHistVld[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        waitResetClear();

        buildTable();
        foreach (rows[i]) applyRow(rows[i]);

        for (i = 0; i < RANDOM_ROWS; i++) begin
            r.op = 2'(randBits(2));
            r.pc = randPc();
            r.pc2 = randPc();
            r.target = randBits(32);
            r.brType = 2'(randBits(2));
            r.taken = 1'(randBits(1));
            r.back = 1'(randBits(1));
            applyRow(r);
            r.op = OP_PRED;
            r.pc = randPc();
            applyRow(r);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/branchPredictor_assertions.sv ====
/*
 * Branch predictor port assertions, bound to the top level.
 */
`timescale 1ns/100ps
`default_nettype none

module branchPredictorAssertions (
    input wire                        clk,
    input wire                        rstn,
    input wire                        buildEn,
    input wire  predictorPkg::addrT   buildPc,
    input wire  predictorPkg::addrT   predPc,
    input wire                        predHit,
    input wire  predictorPkg::brTypeT predType,
    input wire                        predHistVld
);

    // only real branches can occupy a target slot
    hitIsBranch: assert property (@(posedge clk) disable iff (!rstn)
        predHit |-> (predType == predictorPkg::COND || predType == predictorPkg::JUMP))
        else $error("predict hit with a non-branch type");

    resetClears: assert property (@(posedge clk)
        !rstn |=> (!predHit && !predHistVld))
        else $error("valid outputs set right after reset");

    // erase on build, also against a train in the same cycle
    buildErases: assert property (@(posedge clk) disable iff (!rstn)
        buildEn |=> (predPc[6:2] != $past(buildPc[6:2])) || !predHistVld)
        else $error("history still valid after a build of the same slot");

endmodule

bind branchPredictor branchPredictorAssertions u_branchPredictorAssertions (
    .clk         (clk),
    .rstn        (rstn),
    .buildEn     (buildEn),
    .buildPc     (buildPc),
    .predPc      (predPc),
    .predHit     (predHit),
    .predType    (predType),
    .predHistVld (predHistVld)
);

`default_nettype wire
